// ==== design/brightness_timeout.sv ====
// ################################################
// output-enable timer for the latched bit plane
// also flags when the next shift may overlap it
// ################################################
`timescale 1ns/1ps
`include "matrix_defines.svh"

module brightness_timeout (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         row_latch,
    input  matrix_pkg::brightness_mask_t mask_active,
    output logic                         output_enable,
    output logic                         exceeded_overlap
);
    import matrix_pkg::*;

    localparam on_time_t OVERLAP_LIMIT = on_time_t'(`MATRIX_OVERLAP);

    // on-time for the plane now being latched
    on_time_t on_time;
    // cycles of light left including the current one
    on_time_t remaining;
    logic     running;
    logic     running_next;

    // the mask is one-hot so its value is the plane weight
    // planes give 3, 6, 12 or 24 cycles with the default base
    assign on_time = on_time_t'(mask_active * `MATRIX_ON_BASE);

    timeout i_on_timeout (
        .clk_in  (clk_in),
        .reset   (reset),
        .start   (row_latch),
        .value   (on_time),
        .counter (remaining),
        .running (running)
    );

    // what running will be next cycle
    // high from the latch until the count leaves 1
    assign running_next = row_latch || (running && (remaining != on_time_t'(1)));

    // registered copy of the running flag
    // rises the cycle after row_latch and lasts exactly on_time cycles
    always_ff @(posedge clk_in) begin
        if (reset) begin
            output_enable <= 1'b0;
        end else begin
            output_enable <= running_next;
        end
    end

    // near the end of the on-time the scanner may start the next row
    // short planes sit under the limit for their whole on-time
    assign exceeded_overlap = output_enable && (remaining <= OVERLAP_LIMIT);

    // the scanner must wait for dark before latching
    // otherwise a new plane would show with the old on-time running
    a_latch_when_dark: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> !output_enable
    ) else $error("row_latch while output_enable is high");

endmodule

// ==== design/matrix_driver.sv ====
// ################################################
// LED matrix driver top level
// framebuffer and scan sequencer behind plain ports
// ################################################
`timescale 1ns/1ps

module matrix_driver (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      wr_en,
    input  matrix_pkg::col_addr_t      wr_col,
    input  matrix_pkg::pixel_row_t     wr_row,
    input  matrix_pkg::pixel_t         wr_pixel,
    output matrix_pkg::rgb_bits_t      rgb0,
    output matrix_pkg::rgb_bits_t      rgb1,
    output logic                      panel_clk,
    output logic                      row_latch,
    output logic                      output_enable,
    output matrix_pkg::row_sub_addr_t row_address
);

    // high once the framebuffer clear has finished
    logic fb_ready;

    // column, row and plane requests from scanner to framebuffer
    scan_if i_scan_if ();

    matrix_scan i_matrix_scan (
        .clk_in        (clk_in),
        .reset         (reset),
        .fb_ready      (fb_ready),
        .scan          (i_scan_if.scanner),
        .panel_clk     (panel_clk),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_address   (row_address)
    );

    pixel_fetch i_pixel_fetch (
        .clk_in   (clk_in),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_col   (wr_col),
        .wr_row   (wr_row),
        .wr_pixel (wr_pixel),
        .scan     (i_scan_if.fetch),
        .fb_ready (fb_ready),
        .rgb0     (rgb0),
        .rgb1     (rgb1)
    );

endmodule

// ==== design/matrix_pkg.sv ====
// ################################################
// shared types for the LED matrix scan design
// ################################################
`include "matrix_defines.svh"

package matrix_pkg;

    // column within a row
    typedef logic [$clog2(`MATRIX_WIDTH)-1:0] col_addr_t;

    // row inside one half-panel
    typedef logic [$clog2(`MATRIX_SUB_ROWS)-1:0] row_sub_addr_t;

    // row over the full panel height
    // top bit picks the lower half
    typedef logic [$clog2(`MATRIX_SUB_ROWS):0] pixel_row_t;

    // one colour channel of a pixel
    typedef logic [`MATRIX_COLOR_BITS-1:0] channel_t;

    // packed pixel with red in the top bits, then green, then blue
    typedef logic [3*`MATRIX_COLOR_BITS-1:0] pixel_t;

    // one-hot select of the bit plane being shown
    typedef logic [`MATRIX_COLOR_BITS-1:0] brightness_mask_t;

    // red, green and blue bit of one pixel for the current plane
    typedef logic [2:0] rgb_bits_t;

    // on-time and column cycle counters
    typedef logic [7:0] on_time_t;

    // scan sequencer states
    typedef enum logic [1:0] {IDLE, SHIFT, WAIT_DARK, LATCH} scan_state_t;

endpackage

// ==== design/matrix_scan.sv ====
// ################################################
// HUB75 scan sequencer
// column shift, pixel clock, row latch, plane and row advance
// ################################################
`timescale 1ns/1ps
`include "matrix_defines.svh"

module matrix_scan (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      fb_ready,
    scan_if.scanner                   scan,
    output logic                      panel_clk,
    output logic                      row_latch,
    output logic                      output_enable,
    output matrix_pkg::row_sub_addr_t row_address
);
    import matrix_pkg::*;

    // plane order starts at the most significant bit
    localparam brightness_mask_t MASK_MSB = {1'b1, {(`MATRIX_COLOR_BITS-1){1'b0}}};
    // two cycles per column, load then panel clock
    localparam on_time_t COL_CYCLES = on_time_t'(2 * `MATRIX_WIDTH);

    scan_state_t      state;
    scan_state_t      state_next;

    // copies being shifted now and copies whose LEDs are lit
    row_sub_addr_t    row_shift;
    row_sub_addr_t    row_active;
    brightness_mask_t mask_shift;
    brightness_mask_t mask_active;

    // column cycle timer
    on_time_t         col_count;
    on_time_t         col_index;
    logic             col_running;

    logic             shift_go;
    logic             latch_go;
    logic             overlap;
    logic             load;
    logic             load_d1;

    // counts COL_CYCLES down to 1 across the shift
    timeout i_col_timeout (
        .clk_in  (clk_in),
        .reset   (reset),
        .start   (shift_go),
        .value   (COL_CYCLES),
        .counter (col_count),
        .running (col_running)
    );

    // LED on-time for the active plane
    brightness_timeout i_brightness_timeout (
        .clk_in           (clk_in),
        .reset            (reset),
        .row_latch        (row_latch),
        .mask_active      (mask_active),
        .output_enable    (output_enable),
        .exceeded_overlap (overlap)
    );

    // shift once the panel is dark or the on-time is nearly over
    // nothing moves until the framebuffer clear is done
    assign shift_go = (state == IDLE) && fb_ready && (!output_enable || overlap);
    // latch only after the LEDs have gone off
    assign latch_go = (state == WAIT_DARK) && !output_enable;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (shift_go) begin
                    state_next = SHIFT;
                end
            end
            SHIFT: begin
                // count 1 is the data cycle of column 0
                if (col_count == on_time_t'(1)) begin
                    state_next = WAIT_DARK;
                end
            end
            WAIT_DARK: begin
                if (latch_go) begin
                    state_next = LATCH;
                end
            end
            LATCH: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // even counts are load cycles, odd counts are data cycles
    assign load      = (state == SHIFT) && col_running && !col_count[0];
    // count 32 maps to column 15, count 2 to column 0
    assign col_index = col_count >> 1;
    assign scan.col  = col_addr_t'(col_index - 1'b1);
    assign scan.row  = row_shift;
    assign scan.mask = mask_shift;
    assign scan.load = load;

    // pixel data lands one cycle after load
    // the panel samples it one cycle later still
    always_ff @(posedge clk_in) begin
        if (reset) begin
            load_d1   <= 1'b0;
            panel_clk <= 1'b0;
        end else begin
            load_d1   <= load;
            panel_clk <= load_d1;
        end
    end

    assign row_latch   = (state == LATCH);
    assign row_address = row_active;

    // the edge that raises row_latch hands the shifted plane over
    // the shift copy then steps to the next plane
    always_ff @(posedge clk_in) begin
        if (reset) begin
            row_shift   <= '0;
            row_active  <= '0;
            mask_shift  <= MASK_MSB;
            mask_active <= MASK_MSB;
        end else if (latch_go) begin
            row_active  <= row_shift;
            mask_active <= mask_shift;
            if (mask_shift[0]) begin
                // last plane done, move to the next row
                mask_shift <= MASK_MSB;
                row_shift  <= row_shift + 1'b1;
            end else begin
                mask_shift <= mask_shift >> 1;
            end
        end
    end

    // a stray or lost bit would pick no plane or two planes
    a_mask_onehot: assert property (
        @(posedge clk_in) disable iff (reset)
        $onehot(mask_shift) && $onehot(mask_active)
    ) else $error("brightness mask is not one-hot");

endmodule

// ==== design/pixel_fetch.sv ====
// ################################################
// pixel framebuffer with host write port
// feeds bit-plane bits of both half-panels to the panel
// ################################################
`timescale 1ns/1ps
`include "matrix_defines.svh"

module pixel_fetch (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  wr_en,
    input  matrix_pkg::col_addr_t  wr_col,
    input  matrix_pkg::pixel_row_t wr_row,
    input  matrix_pkg::pixel_t     wr_pixel,
    scan_if.fetch                 scan,
    output logic                  fb_ready,
    output matrix_pkg::rgb_bits_t  rgb0,
    output matrix_pkg::rgb_bits_t  rgb1
);
    import matrix_pkg::*;

    // pixels per half-panel
    localparam int HALF_DEPTH = `MATRIX_SUB_ROWS * `MATRIX_WIDTH;
    localparam int SWEEP_BITS = $clog2(HALF_DEPTH);
    localparam int CB         = `MATRIX_COLOR_BITS;

    // address is {full row, column}
    // upper half in the low half of the array
    pixel_t fb_mem [0:2*HALF_DEPTH-1];

    logic [SWEEP_BITS-1:0] sweep_addr;
    pixel_t                upper_px;
    pixel_t                lower_px;

    // pick the plane bit out of each channel
    function automatic rgb_bits_t plane_bits(input pixel_t px, input brightness_mask_t m);
        channel_t red;
        channel_t green;
        channel_t blue;
        red        = px[3*CB-1 -: CB];
        green      = px[2*CB-1 -: CB];
        blue       = px[CB-1 -: CB];
        plane_bits = {|(red & m), |(green & m), |(blue & m)};
    endfunction

    // clear both halves at once, one row-column pair per cycle
    // host writes only land once the sweep has finished
    always_ff @(posedge clk_in) begin
        if (!fb_ready) begin
            fb_mem[{1'b0, sweep_addr}] <= '0;
            fb_mem[{1'b1, sweep_addr}] <= '0;
        end else if (wr_en) begin
            fb_mem[{wr_row, wr_col}] <= wr_pixel;
        end
    end

    // sweep runs for HALF_DEPTH cycles after reset
    always_ff @(posedge clk_in) begin
        if (reset) begin
            sweep_addr <= '0;
            fb_ready   <= 1'b0;
        end else if (!fb_ready) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == SWEEP_BITS'(HALF_DEPTH - 1)) begin
                fb_ready <= 1'b1;
            end
        end
    end

    // row and row + 8 share the scanned column
    assign upper_px = fb_mem[{1'b0, scan.row, scan.col}];
    assign lower_px = fb_mem[{1'b1, scan.row, scan.col}];

    // data held steady until the next load
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb0 <= '0;
            rgb1 <= '0;
        end else if (scan.load) begin
            rgb0 <= plane_bits(upper_px, scan.mask);
            rgb1 <= plane_bits(lower_px, scan.mask);
        end
    end

endmodule

// ==== design/scan_if.sv ====
// ################################################
// scanner to pixel fetch link
// column, row, plane mask and load strobe
// ################################################
`timescale 1ns/1ps

interface scan_if;
    import matrix_pkg::*;

    // column being shifted, counts down from the last column
    col_addr_t        col;
    // half-panel row being shifted
    row_sub_addr_t    row;
    // plane being shifted
    brightness_mask_t mask;
    // one-cycle strobe per column
    logic             load;

    // sequencer side
    modport scanner (output col, output row, output mask, output load);

    // framebuffer side
    modport fetch (input col, input row, input mask, input load);

endinterface

// ==== design/timeout.sv ====
// ################################################
// loadable down-counter that stops at zero
// ################################################
`timescale 1ns/1ps

module timeout (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 start,
    input  matrix_pkg::on_time_t value,
    output matrix_pkg::on_time_t counter,
    output logic                 running
);

    // count down from the loaded value and park at zero
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // busy for as many cycles as were loaded
    assign running = (counter != '0);

    // the user must let a count finish before loading a new one
    // a restart mid-count would cut a column sweep or an on-time short
    a_no_restart: assert property (
        @(posedge clk_in) disable iff (reset)
        start |-> !running
    ) else $error("timeout restarted while still counting");

endmodule

// ==== include/matrix_defines.svh ====
// ################################################
// sizing and timing constants for the LED matrix
// ################################################
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

// columns in one panel row
`define MATRIX_WIDTH 16

// rows in each half-panel
// upper and lower halves are scanned together
`define MATRIX_SUB_ROWS 8

// bits per colour channel
// also the number of bit planes per row
`define MATRIX_COLOR_BITS 4

// on-time cycles for one unit of bit-plane weight
`define MATRIX_ON_BASE 3

// remaining on-time at or below which the next shift may start
`define MATRIX_OVERLAP 20

`endif

// ==== matrix_driver.f ====
+incdir+include
design/matrix_pkg.sv
design/scan_if.sv
design/timeout.sv
design/brightness_timeout.sv
design/matrix_scan.sv
design/pixel_fetch.sv
design/matrix_driver.sv
tb/tb_matrix_driver.sv

// ==== tb/tb_matrix_driver.sv ====
// ################################################
// testbench for the LED matrix driver
// panel model, directed checks of data, plane order and timing
// ################################################
`timescale 1ns/1ps
`include "matrix_defines.svh"

module tb_matrix_driver;
    import matrix_pkg::*;

    localparam int CB           = `MATRIX_COLOR_BITS;
    localparam int COLS         = `MATRIX_WIDTH;
    localparam int ROWS         = `MATRIX_SUB_ROWS;
    localparam int FRAME_PLANES = ROWS * CB;
    localparam int MAX_LATCH    = 128;
    localparam int RESET_CYCLES = 16;
    // two frames of 32 planes near 60 cycles, the writes, and a wide margin
    localparam int CYCLE_LIMIT  = 40000;

    logic          clk_in;
    logic          reset;
    logic          wr_en;
    col_addr_t     wr_col;
    pixel_row_t    wr_row;
    pixel_t        wr_pixel;
    rgb_bits_t     rgb0;
    rgb_bits_t     rgb1;
    logic          panel_clk;
    logic          row_latch;
    logic          output_enable;
    row_sub_addr_t row_address;

    int errors = 0;
    int cycles = 0;

    // host copy of the framebuffer, address is {row, col}
    pixel_t fb_model [0:2*ROWS*COLS-1];

    // panel model state, one record slot per row_latch
    rgb_bits_t     col_q0 [$];
    rgb_bits_t     col_q1 [$];
    rgb_bits_t     cap0 [0:MAX_LATCH-1][0:COLS-1];
    rgb_bits_t     cap1 [0:MAX_LATCH-1][0:COLS-1];
    int            cap_cols [0:MAX_LATCH-1];
    row_sub_addr_t lat_row [0:MAX_LATCH-1];
    int            lat_cycle [0:MAX_LATCH-1];
    on_time_t      pulse_len [0:MAX_LATCH-1];
    row_sub_addr_t pulse_row [0:MAX_LATCH-1];
    logic          pulse_done [0:MAX_LATCH-1];
    logic          first_clk_lit [0:MAX_LATCH-1];
    int            latch_count = 0;
    int            oe_cycles = 0;
    logic          oe_prev = 1'b0;
    logic          clk_seen = 1'b1;
    int            both_high = 0;
    int            early_clk = 0;

    matrix_driver i_dut (
        .clk_in        (clk_in),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_col        (wr_col),
        .wr_row        (wr_row),
        .wr_pixel      (wr_pixel),
        .rgb0          (rgb0),
        .rgb1          (rgb1),
        .panel_clk     (panel_clk),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_address   (row_address)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
    end

    // latch k shows bit plane MSB first, four planes per row, rows wrap at 8
    function automatic int plane_bit(input int k);
        plane_bit = CB - 1 - (k % CB);
    endfunction

    function automatic row_sub_addr_t plane_row(input int k);
        plane_row = row_sub_addr_t'((k / CB) % ROWS);
    endfunction

    function automatic on_time_t plane_on_time(input int k);
        plane_on_time = on_time_t'((1 << plane_bit(k)) * `MATRIX_ON_BASE);
    endfunction

    // bit b of red, green and blue
    function automatic rgb_bits_t pixel_plane(input pixel_t px, input int b);
        pixel_plane = {px[2*CB + b], px[CB + b], px[b]};
    endfunction

    // panel model, sampled mid-cycle where outputs are settled
    always @(negedge clk_in) begin
        int k;
        if (!reset) begin
            k = latch_count - 1;
            if (output_enable) begin
                if (!oe_prev && k >= 0) begin
                    pulse_row[k] = row_address;
                end
                oe_cycles = oe_cycles + 1;
            end
            if (panel_clk) begin
                col_q0.push_back(rgb0);
                col_q1.push_back(rgb1);
                if (!clk_seen && k >= 0) begin
                    first_clk_lit[k] = output_enable;
                    clk_seen = 1'b1;
                end
                // remaining on-time counts the current cycle
                if (output_enable && k >= 0 &&
                    (int'(plane_on_time(k)) - oe_cycles + 1 > `MATRIX_OVERLAP + 3)) begin
                    early_clk++;
                end
            end
            if (oe_prev && !output_enable && k >= 0) begin
                pulse_len[k]  = on_time_t'(oe_cycles);
                pulse_done[k] = 1'b1;
                oe_cycles     = 0;
            end
            if (row_latch) begin
                if (output_enable) begin
                    both_high++;
                end
                if (latch_count < MAX_LATCH) begin
                    cap_cols[latch_count]  = col_q0.size();
                    lat_row[latch_count]   = row_address;
                    lat_cycle[latch_count] = cycles;
                    for (int j = 0; j < COLS; j++) begin
                        cap0[latch_count][j] = (j < col_q0.size()) ? col_q0[j] : 3'bxxx;
                        cap1[latch_count][j] = (j < col_q1.size()) ? col_q1[j] : 3'bxxx;
                    end
                end
                col_q0.delete();
                col_q1.delete();
                latch_count++;
                clk_seen = 1'b0;
            end
            oe_prev = output_enable;
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_bits_t got, input rgb_bits_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input string name, input row_sub_addr_t got,
                             input row_sub_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input brightness_mask_t got,
                              input brightness_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_on_time(input string name, input on_time_t got, input on_time_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic wait_latches(input int n);
        while (latch_count < n) begin
            @(posedge clk_in);
        end
    endtask

    task automatic check_quiet_outputs();
        check_bit("panel_clk", panel_clk, 1'b0);
        check_bit("row_latch", row_latch, 1'b0);
        check_bit("output_enable", output_enable, 1'b0);
        check_row("row_address", row_address, '0);
        check_rgb("rgb0", rgb0, '0);
        check_rgb("rgb1", rgb1, '0);
    endtask

    // 16 columns per latch, shifted from column 15 down to 0
    task automatic check_plane_data(input int k);
        int            b;
        row_sub_addr_t r;
        col_addr_t     c;
        b = plane_bit(k);
        r = plane_row(k);
        if (cap_cols[k] != COLS) begin
            errors++;
            $display("latch %0d came after %0d pixel clocks instead of %0d", k, cap_cols[k], COLS);
        end
        for (int j = 0; j < COLS; j++) begin
            c = col_addr_t'(COLS - 1 - j);
            check_rgb($sformatf("rgb0 latch %0d col %0d", k, c), cap0[k][j],
                      pixel_plane(fb_model[{1'b0, r, c}], b));
            check_rgb($sformatf("rgb1 latch %0d col %0d", k, c), cap1[k][j],
                      pixel_plane(fb_model[{1'b1, r, c}], b));
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk_in);
            if (i == RESET_CYCLES - 1) begin
                reset <= 1'b0;
            end
            @(negedge clk_in);
            check_quiet_outputs();
        end
        // first cycle out of reset
        @(negedge clk_in);
        check_quiet_outputs();
    endtask

    task automatic test_cleared_frame();
        wait_latches(FRAME_PLANES);
        for (int k = 0; k < FRAME_PLANES; k++) begin
            check_plane_data(k);
        end
    endtask

    task automatic test_shifted_data();
        pixel_t px;
        int     first;
        for (int i = 0; i < 2*ROWS*COLS; i++) begin
            px = pixel_t'($urandom);
            @(posedge clk_in);
            wr_en       <= 1'b1;
            wr_row      <= pixel_row_t'(i / COLS);
            wr_col      <= col_addr_t'(i % COLS);
            wr_pixel    <= px;
            fb_model[i] = px;
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
        @(posedge clk_in);
        // the plane in flight may mix old and new pixels
        first = latch_count + 1;
        wait_latches(first + FRAME_PLANES);
        for (int k = first; k < first + FRAME_PLANES; k++) begin
            check_plane_data(k);
        end
    endtask

    task automatic test_plane_order();
        if (latch_count < 9 * CB) begin
            errors++;
            $display("only %0d row latches seen, fewer than nine rows", latch_count);
        end
        for (int k = 0; k < latch_count && k < MAX_LATCH; k++) begin
            check_row($sformatf("row_address at latch %0d cycle %0d", k, lat_cycle[k]),
                      lat_row[k], plane_row(k));
            if (pulse_done[k]) begin
                // plane weight recovered from the lit time
                check_mask($sformatf("plane of latch %0d", k),
                           brightness_mask_t'(pulse_len[k] / `MATRIX_ON_BASE),
                           brightness_mask_t'(1 << plane_bit(k)));
                check_row($sformatf("row_address while lit %0d", k), pulse_row[k], plane_row(k));
            end
        end
    endtask

    task automatic test_on_time();
        for (int k = 0; k < latch_count && k < MAX_LATCH; k++) begin
            if (pulse_done[k]) begin
                check_on_time($sformatf("output_enable length %0d", k), pulse_len[k],
                              plane_on_time(k));
            end else if (k + 1 < latch_count) begin
                errors++;
                $display("no output_enable pulse ended between latch %0d and the next", k);
            end
        end
        if (both_high != 0) begin
            errors++;
            $display("row_latch was high with output_enable in %0d cycles", both_high);
        end
    endtask

    task automatic test_overlap();
        for (int k = 0; k + 1 < latch_count && k < MAX_LATCH; k++) begin
            if (plane_bit(k) == CB - 1) begin
                check_bit($sformatf("output_enable at first panel_clk after %0d", k),
                          first_clk_lit[k], 1'b1);
            end
        end
        if (early_clk != 0) begin
            errors++;
            $display("%0d pixel clocks came with more than the overlap time left", early_clk);
        end
    endtask

    initial begin
        reset    <= 1'b1;
        wr_en    <= 1'b0;
        wr_col   <= '0;
        wr_row   <= '0;
        wr_pixel <= '0;
        void'($urandom(32'hdf108dbb));
        // cleared framebuffer as the panel should see it
        for (int i = 0; i < 2*ROWS*COLS; i++) begin
            fb_model[i] = '0;
        end
        for (int i = 0; i < MAX_LATCH; i++) begin
            pulse_done[i]    = 1'b0;
            first_clk_lit[i] = 1'b0;
        end
        test_reset();
        test_cleared_frame();
        test_shifted_data();
        test_plane_order();
        test_on_time();
        test_overlap();
        $display("errors %0d, row latches %0d, early pixel clocks %0d, latch with enable %0d",
                 errors, latch_count, early_clk, both_high);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // stop a stalled scan
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_in);
        end
        $display("run stopped after %0d cycles with %0d row latches seen", cycles, latch_count);
        $display("TB FAILED");
        $finish;
    end

endmodule
